/* logic/mem_pkg.sv */
// memory port widths, port stride and the address and word types
package mem_pkg;

  localparam int unsigned ADDR_W         = 32; // byte address
  localparam int unsigned WORD_W         = 32; // data per port
  localparam int unsigned BYTES_PER_WORD = WORD_W / 8; // offset between adjacent ports

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

endpackage

/* logic/stream_pkg.sv */
// lane depth, configuration struct and controller states of the streamer
package stream_pkg;

  localparam int unsigned LANE_DEPTH  = 2;  // slots per lane, also the initial credit
  localparam int unsigned MAX_TRANS_W = 16; // widest beat counter the config can carry

  typedef logic [MAX_TRANS_W-1:0] count_t;

  // IDLE waits for start, ISSUE sends beats, DRAIN waits for the stream to empty
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    DRAIN = 2'd2
  } ctrl_state_e;

  typedef struct packed {
    mem_pkg::addr_t base;   // first beat address
    mem_pkg::addr_t stride; // bytes between beats, may be zero
    count_t         count;  // beats in the transfer
  } stream_cfg_t;

endpackage

/* logic/mem_port_if.sv */
// one memory port, request and response side, with requester, memory and response modports
`timescale 1ns/10ps

interface mem_port_if;

  logic           req;     // held with stable add until gnt
  mem_pkg::addr_t add;     // byte address
  logic           gnt;     // request taken this cycle
  mem_pkg::word_t r_data;  // read word
  logic           r_valid; // exactly one cycle after gnt

  // streamer side issuing loads
  modport requester (
    output req, add,
    input  gnt, r_data, r_valid
  );

  // memory side, answering loads
  modport memory (
    input  req, add,
    output gnt, r_data, r_valid
  );

  // observer of grants and returning data, no drive
  modport resp (
    input req, gnt, r_data, r_valid
  );

endinterface

/* logic/cfg_regs.sv */
// configuration registers captured on an accepted start, with same-cycle bypass
`timescale 1ns/10ps

module cfg_regs #(
  parameter int unsigned TRANS_W = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    capture_i,
  input  mem_pkg::addr_t          base_addr_i,
  input  mem_pkg::addr_t          stride_i,
  input  logic [TRANS_W-1:0]      beat_count_i,
  output stream_pkg::stream_cfg_t cfg_o
);

  stream_pkg::stream_cfg_t cfg_in, cfg_q;

  assign cfg_in.base   = base_addr_i;
  assign cfg_in.stride = stride_i;
  assign cfg_in.count  = stream_pkg::count_t'(beat_count_i); // zero extended to the field

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (clear_i) begin
      cfg_q <= '0;
    end else if (capture_i) begin
      cfg_q <= cfg_in; // held for the whole transfer
    end
  end

  // addr_gen loads in the start cycle, so it sees the new values directly
  assign cfg_o = capture_i ? cfg_in : cfg_q;

  // shortest transfer spans four busy cycles before the FSM is back in IDLE
  a_no_recapture : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    capture_i |=> !capture_i [*3]);

endmodule

/* logic/addr_gen.sv */
// beat address generator and remaining-beat counter
`timescale 1ns/10ps

module addr_gen #(
  parameter int unsigned TRANS_W = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    load_i,    // start accepted
  input  logic                    advance_i, // beat fully granted
  input  stream_pkg::stream_cfg_t cfg_i,
  output mem_pkg::addr_t          beat_addr_o,
  output logic                    last_beat_o
);

  mem_pkg::addr_t     addr_q;
  logic [TRANS_W-1:0] remain_q; // beats still to issue, current one included

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      remain_q <= '0;
    end else if (clear_i) begin
      addr_q   <= '0;
      remain_q <= '0;
    end else if (load_i) begin
      addr_q   <= cfg_i.base;
      remain_q <= cfg_i.count[TRANS_W-1:0]; // upper field bits unused
    end else if (advance_i) begin
      addr_q   <= addr_q + cfg_i.stride; // stride 0 rereads the same words
      remain_q <= remain_q - TRANS_W'(1);
    end
  end

  assign beat_addr_o = addr_q;
  assign last_beat_o = (remain_q == TRANS_W'(1));

  // the controller leaves ISSUE on the last beat, so the counter never underflows
  a_no_extra_beat : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    advance_i |-> remain_q != '0);

endmodule

/* logic/load_ctrl.sv */
// streamer FSM, per-port grant tracking, credit-gated beat issue and done generation
`timescale 1ns/10ps

module load_ctrl #(
  parameter int unsigned NB_PORTS = 2,
  parameter int unsigned TRANS_W  = 16
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  logic           start_i,
  output logic           ready_start_o,
  output logic           capture_o,
  output logic           gen_load_o,
  output logic           gen_advance_o,
  input  mem_pkg::addr_t beat_addr_i,
  input  logic           last_beat_i,
  input  logic           lanes_have_credit_i,
  input  logic           beat_accepted_i,
  output logic           done_o,
  mem_port_if.requester  mem [NB_PORTS-1:0]
);

  stream_pkg::ctrl_state_e state_q, state_d;
  logic [NB_PORTS-1:0] granted_q; // port already served in this beat
  logic [NB_PORTS-1:0] port_req, port_gnt, port_hs;
  logic                beat_active_q, beat_go, beat_issue;
  logic                accept_start, last_accept, done_q;
  logic [TRANS_W-1:0]  out_cnt_q; // beats issued but not yet accepted downstream

  assign ready_start_o = (state_q == stream_pkg::IDLE);
  assign accept_start  = ready_start_o & start_i;
  assign capture_o     = accept_start;
  assign gen_load_o    = accept_start;

  // a beat opens only with a credit in every lane, then stays open until all ports are served
  assign beat_go    = (state_q == stream_pkg::ISSUE) & (beat_active_q | lanes_have_credit_i);
  assign port_req   = {NB_PORTS{beat_go}} & ~granted_q;
  assign port_hs    = port_req & port_gnt;
  assign beat_issue = beat_go & (&(granted_q | port_hs)); // last port granted now
  assign gen_advance_o = beat_issue;
  assign last_accept   = beat_accepted_i & (out_cnt_q == TRANS_W'(1));

  for (genvar i = 0; i < NB_PORTS; i++) begin : gen_port
    assign mem[i].req  = port_req[i];
    assign mem[i].add  = beat_addr_i + mem_pkg::addr_t'(i * mem_pkg::BYTES_PER_WORD);
    assign port_gnt[i] = mem[i].gnt;

    // a waiting port keeps asking for the same word
    a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      mem[i].req && !mem[i].gnt |=> mem[i].req && $stable(mem[i].add));
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      stream_pkg::IDLE:  if (accept_start) state_d = stream_pkg::ISSUE;
      stream_pkg::ISSUE: if (beat_issue && last_beat_i) state_d = stream_pkg::DRAIN;
      stream_pkg::DRAIN: if (last_accept) state_d = stream_pkg::IDLE;
      default:           state_d = stream_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= stream_pkg::IDLE;
      granted_q     <= '0;
      beat_active_q <= 1'b0;
      out_cnt_q     <= '0;
      done_q        <= 1'b0;
    end else if (clear_i) begin
      state_q       <= stream_pkg::IDLE;
      granted_q     <= '0;
      beat_active_q <= 1'b0;
      out_cnt_q     <= '0;
      done_q        <= 1'b0;
    end else begin
      state_q       <= state_d;
      granted_q     <= beat_issue ? '0 : (granted_q | port_hs);
      beat_active_q <= beat_go & ~beat_issue;
      out_cnt_q     <= out_cnt_q + TRANS_W'(beat_issue) - TRANS_W'(beat_accepted_i);
      done_q        <= (state_q == stream_pkg::DRAIN) & last_accept; // with the IDLE return
    end
  end

  assign done_o = done_q;

endmodule

/* logic/resp_merge.sv */
// per-lane response FIFOs, lane credit counters and merge into the wide output stream
`timescale 1ns/10ps

module resp_merge #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  mem_port_if.resp                      mem [NB_PORTS-1:0],
  output logic                          lanes_have_credit_o,
  output logic                          beat_accepted_o,
  output logic                          stream_valid_o,
  output mem_pkg::word_t [NB_PORTS-1:0] stream_data_o,
  input  logic                          stream_ready_i
);

  localparam int unsigned DEPTH = stream_pkg::LANE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [NB_PORTS-1:0] lane_filled, lane_credit;
  logic                pop; // all lanes leave together

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign stream_valid_o      = &lane_filled; // one word waiting in every lane
  assign pop                 = stream_valid_o & stream_ready_i;
  assign beat_accepted_o     = pop;
  assign lanes_have_credit_o = &lane_credit;

  for (genvar i = 0; i < NB_PORTS; i++) begin : gen_lane
    mem_pkg::word_t   slot_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] fill_q;
    logic [CNT_W-1:0] credit_q; // free slots minus loads in flight
    logic             expect_q; // grant seen last cycle, data due now
    logic             taken, push;

    assign taken = mem[i].req & mem[i].gnt;
    assign push  = mem[i].r_valid & expect_q; // drops returns of loads granted before a clear

    always_ff @(posedge clk_i) begin
      if (push) slot_q[wr_ptr_q] <= mem[i].r_data;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
        credit_q <= CNT_W'(DEPTH);
        expect_q <= 1'b0;
      end else if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
        credit_q <= CNT_W'(DEPTH);
        expect_q <= 1'b0;
      end else begin
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
        fill_q   <= fill_q + CNT_W'(push) - CNT_W'(pop);
        credit_q <= credit_q - CNT_W'(taken) + CNT_W'(pop); // slot returns on pop
        expect_q <= taken;
      end
    end

    assign lane_filled[i]   = (fill_q != '0);
    assign lane_credit[i]   = (credit_q != '0);
    assign stream_data_o[i] = slot_q[rd_ptr_q]; // head of lane

    // credit gating upstream keeps every grant backed by a free slot
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      push |-> fill_q != CNT_W'(DEPTH));
  end

endmodule

/* logic/load_streamer.sv */
// load streamer top level, flat memory and stream ports around the control and merge blocks
`timescale 1ns/10ps

module load_streamer #(
  parameter int unsigned NB_PORTS = 2,
  parameter int unsigned TRANS_W  = 16 // up to stream_pkg::MAX_TRANS_W
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  mem_pkg::addr_t                base_addr_i,
  input  mem_pkg::addr_t                stride_i,
  input  logic [TRANS_W-1:0]            beat_count_i,
  output logic                          ready_start_o,
  output logic                          done_o,
  output logic [NB_PORTS-1:0]           mem_req_o,
  output mem_pkg::addr_t [NB_PORTS-1:0] mem_add_o,
  input  logic [NB_PORTS-1:0]           mem_gnt_i,
  input  mem_pkg::word_t [NB_PORTS-1:0] mem_r_data_i,
  input  logic [NB_PORTS-1:0]           mem_r_valid_i,
  output logic                          stream_valid_o,
  output mem_pkg::word_t [NB_PORTS-1:0] stream_data_o,
  input  logic                          stream_ready_i
);

  stream_pkg::stream_cfg_t cfg;
  mem_pkg::addr_t          beat_addr;
  logic capture, gen_load, gen_advance, last_beat;
  logic lanes_have_credit, beat_accepted;

  mem_port_if mem_ports [NB_PORTS-1:0] ();

  for (genvar g = 0; g < NB_PORTS; g++) begin : gen_flat
    assign mem_req_o[g]         = mem_ports[g].req;
    assign mem_add_o[g]         = mem_ports[g].add;
    assign mem_ports[g].gnt     = mem_gnt_i[g];
    assign mem_ports[g].r_data  = mem_r_data_i[g];
    assign mem_ports[g].r_valid = mem_r_valid_i[g];
  end

  cfg_regs #(.TRANS_W(TRANS_W)) u_cfg_regs (
    .clk_i, .rst_ni, .clear_i,
    .capture_i    (capture),
    .base_addr_i,
    .stride_i,
    .beat_count_i,
    .cfg_o        (cfg)
  );

  addr_gen #(.TRANS_W(TRANS_W)) u_addr_gen (
    .clk_i, .rst_ni, .clear_i,
    .load_i      (gen_load),
    .advance_i   (gen_advance),
    .cfg_i       (cfg),
    .beat_addr_o (beat_addr),
    .last_beat_o (last_beat)
  );

  load_ctrl #(.NB_PORTS(NB_PORTS), .TRANS_W(TRANS_W)) u_load_ctrl (
    .clk_i, .rst_ni, .clear_i, .start_i, .ready_start_o,
    .capture_o           (capture),
    .gen_load_o          (gen_load),
    .gen_advance_o       (gen_advance),
    .beat_addr_i         (beat_addr),
    .last_beat_i         (last_beat),
    .lanes_have_credit_i (lanes_have_credit),
    .beat_accepted_i     (beat_accepted),
    .done_o,
    .mem                 (mem_ports)
  );

  resp_merge #(.NB_PORTS(NB_PORTS)) u_resp_merge (
    .clk_i, .rst_ni, .clear_i,
    .mem                 (mem_ports),
    .lanes_have_credit_o (lanes_have_credit),
    .beat_accepted_o     (beat_accepted),
    .stream_valid_o, .stream_data_o, .stream_ready_i
  );

endmodule

/* verification/mem_model.sv */
// banked memory responder, one bank per port, testbench-gated grants, address-derived read data
`timescale 1ns/10ps

module mem_model #(
  parameter int unsigned NB_PORTS = 2,
  parameter logic [31:0] DATA_KEY = 32'h5a5a0000 // read word is address ^ key
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [NB_PORTS-1:0]           gnt_allow_i, // bank free this cycle
  input  logic [NB_PORTS-1:0]           mem_req_i,
  input  mem_pkg::addr_t [NB_PORTS-1:0] mem_add_i,
  output logic [NB_PORTS-1:0]           mem_gnt_o,
  output mem_pkg::word_t [NB_PORTS-1:0] mem_r_data_o,
  output logic [NB_PORTS-1:0]           mem_r_valid_o
);

  assign mem_gnt_o = mem_req_i & gnt_allow_i; // busy bank only delays the grant

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_r_valid_o <= '0;
      mem_r_data_o  <= '0;
    end else begin
      mem_r_valid_o <= mem_gnt_o; // fixed one cycle read latency
      for (int i = 0; i < NB_PORTS; i++) begin
        if (mem_gnt_o[i]) begin
          mem_r_data_o[i] <= mem_add_i[i] ^ DATA_KEY; // whole address shapes the word
        end else begin
          mem_r_data_o[i] <= 32'hdead_beef; // poison between reads
        end
      end
    end
  end

endmodule

/* verification/tb_load_streamer.sv */
// load streamer testbench with clock, reset, random grants and back-pressure, reference beats
`timescale 1ns/10ps

module tb_load_streamer;

  localparam int unsigned NB_PORTS  = 2;
  localparam int unsigned TRANS_W   = 16;
  localparam int unsigned STREAM_W  = NB_PORTS * mem_pkg::WORD_W;
  localparam logic [31:0] SEED      = 32'h344d6164;
  localparam logic [31:0] DATA_KEY  = 32'h5a5a0000;
  localparam int          N_BTB     = 6; // back-to-back transfers
  localparam int          MAX_BEATS = 8 + 16 + 16 + N_BTB * 16 + 12 + 8;
  localparam int          LIMIT_NS  = (MAX_BEATS * 40 + 200) * 8; // 40 cycles per beat

  logic clk, rst_n, clear, start, ready_start, done;
  logic stream_valid, stream_ready, busy, hold, done_prev;
  logic random_gnt, random_ready;
  logic [4:0] stall_cnt; // cycles of forced back-pressure left
  mem_pkg::addr_t base_addr, stride;
  logic [TRANS_W-1:0] beat_count;
  logic [NB_PORTS-1:0] mem_req, mem_gnt, mem_r_valid, gnt_allow;
  mem_pkg::addr_t [NB_PORTS-1:0] mem_add;
  mem_pkg::word_t [NB_PORTS-1:0] mem_r_data, stream_data;
  logic [STREAM_W-1:0] held_data;
  logic [STREAM_W-1:0] exp_q [$]; // reference beats still to arrive
  logic [31:0] cfg_rng, bus_rng;
  int errors, checks, tests, test_errors, done_cnt, done_base;

  load_streamer #(.NB_PORTS(NB_PORTS), .TRANS_W(TRANS_W)) u_dut (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear), .start_i(start),
    .base_addr_i(base_addr), .stride_i(stride), .beat_count_i(beat_count),
    .ready_start_o(ready_start), .done_o(done),
    .mem_req_o(mem_req), .mem_add_o(mem_add), .mem_gnt_i(mem_gnt),
    .mem_r_data_i(mem_r_data), .mem_r_valid_i(mem_r_valid),
    .stream_valid_o(stream_valid), .stream_data_o(stream_data),
    .stream_ready_i(stream_ready)
  );

  mem_model #(.NB_PORTS(NB_PORTS), .DATA_KEY(DATA_KEY)) u_mem (
    .clk_i(clk), .rst_ni(rst_n), .gnt_allow_i(gnt_allow),
    .mem_req_i(mem_req), .mem_add_i(mem_add), .mem_gnt_o(mem_gnt),
    .mem_r_data_o(mem_r_data), .mem_r_valid_o(mem_r_valid)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic check_eq(input logic [STREAM_W-1:0] got, want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, want);
    end
  endtask

  // lane i of beat k reads base + k*stride + 4i
  task automatic push_expected(input mem_pkg::addr_t b, s, input logic [TRANS_W-1:0] c);
    logic [STREAM_W-1:0] beat;
    mem_pkg::addr_t      word;
    for (int k = 0; k < int'(c); k++) begin
      for (int i = 0; i < int'(NB_PORTS); i++) begin
        word = b + mem_pkg::addr_t'(k) * s + mem_pkg::addr_t'(4 * i);
        beat = {word ^ DATA_KEY, beat[STREAM_W-1:mem_pkg::WORD_W]}; // lane 0 ends lowest
      end
      exp_q.push_back(beat);
    end
  endtask

  task automatic rand_cfg(output mem_pkg::addr_t b, s, output logic [TRANS_W-1:0] c);
    cfg_rng = xorshift(cfg_rng);
    b = {cfg_rng[31:2], 2'b00};
    cfg_rng = xorshift(cfg_rng);
    s = {22'd0, cfg_rng[9:2], 2'b00};
    c = TRANS_W'(cfg_rng[13:10]) + TRANS_W'(1); // 1 to 16 beats
  endtask

  // entered and left 1 ns after a rising edge, DUT idle on entry
  task automatic begin_transfer(input mem_pkg::addr_t b, s, input logic [TRANS_W-1:0] c,
                                input logic retry);
    push_expected(b, s, c);
    base_addr  = b;
    stride     = s;
    beat_count = c;
    start      = 1'b1;
    @(posedge clk);
    #1;
    busy      = 1'b1;
    start     = retry; // second start with junk config while busy
    base_addr = ~b;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (!done) @(negedge clk); // watchdog bounds this
    busy = 1'b0;
    check_eq(STREAM_W'(exp_q.size()), '0, "beats missing at done_o");
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input string what);
    check_eq(STREAM_W'(ready_start), STREAM_W'(1), {"ready_start_o ", what});
    check_eq(STREAM_W'(done), '0, {"done_o ", what});
    check_eq(STREAM_W'(stream_valid), '0, {"stream_valid_o ", what});
    check_eq(STREAM_W'(mem_req), '0, {"mem_req_o ", what});
  endtask

  task automatic end_test(input string name, input int xfers);
    check_eq(STREAM_W'(done_cnt - done_base), STREAM_W'(xfers), {"done_o pulses in ", name});
    tests++;
    $display("test %0d, %s: %s", tests, name, (errors == test_errors) ? "ok" : "errors seen");
    test_errors = errors;
    done_base   = done_cnt;
  endtask

  // grants and ready change 1 ns after the edge
  always @(posedge clk) begin
    #1;
    bus_rng   = xorshift(bus_rng);
    gnt_allow = random_gnt ? bus_rng[NB_PORTS-1:0] : '1;
    if (!random_ready) begin
      stream_ready = 1'b1;
    end else if (stall_cnt != '0) begin
      stream_ready = 1'b0; // long stall
      stall_cnt    = stall_cnt - 5'd1;
    end else begin
      stream_ready = bus_rng[8];
      if (bus_rng[15:12] == 4'd0) stall_cnt = bus_rng[20:16];
    end
  end

  // output side sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold) begin
        check_eq(STREAM_W'(stream_valid), STREAM_W'(1), "stream_valid_o dropped while stalled");
        check_eq(stream_data, held_data, "stream_data_o changed while stalled");
      end
      if (stream_valid && stream_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("an output beat appeared at %0t with no beat expected", $time);
        end else begin
          check_eq(stream_data, exp_q.pop_front(), "output beat");
        end
      end
      if (done) begin
        done_cnt++;
        if (exp_q.size() != 0 || done_prev) begin
          errors++;
          $display("done_o at %0t came before the last beat or lasted two cycles", $time);
        end
      end
      if (busy && !done) check_eq(STREAM_W'(ready_start), '0, "ready_start_o while busy");
      hold      = stream_valid && !stream_ready && !clear;
      held_data = stream_data;
      done_prev = done;
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired after %0d ns, a transfer never finished", LIMIT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    mem_pkg::addr_t     b, s;
    logic [TRANS_W-1:0] c;
    clk          = 1'b0;
    rst_n        = 1'b0;
    clear        = 1'b0;
    start        = 1'b0;
    base_addr    = '0;
    stride       = '0;
    beat_count   = '0;
    stream_ready = 1'b1;
    gnt_allow    = '1;
    random_gnt   = 1'b0;
    random_ready = 1'b0;
    stall_cnt    = '0;
    busy         = 1'b0;
    hold         = 1'b0;
    done_prev    = 1'b0;
    cfg_rng      = SEED;
    bus_rng      = SEED ^ 32'h9e3779b9; // second stream from the same seed
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle("after reset");
    end_test("reset values", 0);
    @(posedge clk);
    #1;

    begin_transfer(32'h0000_1000, 32'h40, TRANS_W'(8), 1'b0);
    wait_done();
    end_test("single transfer, no stalls", 1);

    random_gnt = 1'b1;
    rand_cfg(b, s, c);
    begin_transfer(b, s, TRANS_W'(16), 1'b0);
    wait_done();
    end_test("random grants", 1);

    random_ready = 1'b1;
    rand_cfg(b, s, c);
    begin_transfer(b, s, TRANS_W'(16), 1'b0);
    wait_done();
    end_test("random ready with stalls", 1);

    for (int n = 0; n < N_BTB; n++) begin
      rand_cfg(b, s, c);
      if (n == 1) s = '0;          // every beat rereads the same words
      if (n == 3) c = TRANS_W'(1); // shortest transfer
      begin_transfer(b, s, c, 1'b1);
      wait_done();
    end
    end_test("back-to-back random configs", N_BTB);

    rand_cfg(b, s, c);
    begin_transfer(b, s, TRANS_W'(12), 1'b0);
    repeat (8) @(posedge clk);
    #1;
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear = 1'b0;
    exp_q.delete(); // aborted beats are gone
    busy  = 1'b0;
    @(negedge clk);
    check_idle("after clear");
    @(posedge clk);
    #1;
    rand_cfg(b, s, c);
    begin_transfer(b, s, TRANS_W'(8), 1'b0);
    wait_done();
    end_test("clear mid-transfer", 1);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
logic/mem_pkg.sv
logic/stream_pkg.sv
logic/mem_port_if.sv
logic/cfg_regs.sv
logic/addr_gen.sv
logic/load_ctrl.sv
logic/resp_merge.sv
logic/load_streamer.sv
verification/mem_model.sv
verification/tb_load_streamer.sv

/* Makefile */
# Verilator run of the load streamer testbench, pass decided from the log
BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_load_streamer -Mdir $(BUILD) -f all.f
	$(BUILD)/Vtb_load_streamer | tee sim.log
	grep -qx "TEST PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
